/* row_buffer_top.f */
logic/rowbuf_pkg.sv
logic/rowbuf_mem_if.sv
logic/rowbuf_ram.sv
logic/row_writer.sv
logic/window_reader.sv
logic/rowbuf_arbiter.sv
logic/row_buffer_top.sv
tests/row_buffer_sva.sv
tests/row_buffer_checker.sv
tests/row_buffer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := row_buffer_tb
FILELIST  := row_buffer_top.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, not the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/row_buffer_tb.sv */
`timescale 1ns/1ps

module row_buffer_tb;

    localparam int PIXEL_WIDTH = 18;
    localparam int MAX_COLS    = 512;
    localparam int COL_W       = $clog2(MAX_COLS);
    localparam int WIN_W       = rowbuf_pkg::WIN_PIXELS * PIXEL_WIDTH;
    // Window requests per batch, the last one at the last legal column
    localparam int WINDOWS     = 6;

    logic                   clk;
    logic                   rst;
    logic [COL_W-1:0]       num_cols;
    logic [PIXEL_WIDTH-1:0] pixel_data;
    logic                   pixel_req;
    logic                   pixel_ack;
    logic [COL_W-1:0]       win_col;
    logic                   win_req;
    logic                   win_ack;
    logic [WIN_W-1:0]       win_data;
    logic                   rows_ready;
    logic [COL_W-1:0]       cols_a;
    logic [COL_W-1:0]       cols_b;

    int seed           = 22;
    int sent           = 0;
    int tb_errors      = 0;
    int errors_before  = 0;
    int tests_passed   = 0;
    int tests_failed   = 0;
    int timeout_cycles = 0;
    int chk_errors;
    int chk_acked;

    row_buffer_top #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) uut (
        .clk        (clk),
        .rst        (rst),
        .num_cols   (num_cols),
        .pixel_data (pixel_data),
        .pixel_req  (pixel_req),
        .pixel_ack  (pixel_ack),
        .win_col    (win_col),
        .win_req    (win_req),
        .win_ack    (win_ack),
        .win_data   (win_data),
        .rows_ready (rows_ready)
    );

    row_buffer_checker #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) chk (
        .clk        (clk),
        .rst        (rst),
        .num_cols   (num_cols),
        .pixel_data (pixel_data),
        .pixel_ack  (pixel_ack),
        .win_col    (win_col),
        .win_req    (win_req),
        .win_ack    (win_ack),
        .win_data   (win_data),
        .rows_ready (rows_ready),
        .errors     (chk_errors),
        .acked      (chk_acked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Budget of 20 cycles per planned pixel and window
    initial begin
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a handshake never completed",
                 timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers, all driven 1 ns after the clock edge
    ////////////////////////////////////////////////////////////

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic apply_reset(input logic [COL_W-1:0] cols);
        rst       = 1'b1;
        num_cols  = cols;
        pixel_req = 1'b0;
        win_req   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic send_pixel(input int max_wait);
        pixel_data = PIXEL_WIDTH'($random(seed));
        pixel_req  = 1'b1;
        sent++;
        do @(posedge clk); while (!pixel_ack);
        repeat (rand_range(0, max_wait)) @(posedge clk);
        #1;
        pixel_req = 1'b0;
        do @(posedge clk); while (pixel_ack);
        #1;
    endtask

    task automatic send_row(input int max_wait);
        repeat (num_cols) send_pixel(max_wait);
    endtask

    task automatic request_window(input logic [COL_W-1:0] col);
        win_col = col;
        win_req = 1'b1;
        do @(posedge clk); while (!win_ack);
        repeat (rand_range(0, 3)) @(posedge clk);
        #1;
        win_req = 1'b0;
        do @(posedge clk); while (win_ack);
        #1;
    endtask

    task automatic check_windows();
        repeat (WINDOWS - 1) begin
            request_window(COL_W'(rand_range(0, int'(num_cols) - 2)));
        end
        request_window(num_cols - COL_W'(2));
    endtask

    task automatic expect_rows_ready(input logic exp);
        if (rows_ready !== exp) begin
            tb_errors++;
            $display("ERR t=%0t rows_ready exp=%0b got=%0b", $time, exp, rows_ready);
        end
    endtask

    task automatic finish_test(input string name);
        int now_errors;
        now_errors = chk_errors + tb_errors + uut.u_arbiter.arbiter_sva.fail_cnt;
        if (now_errors == errors_before) begin
            tests_passed++;
            $display("Test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("Test %-12s failed with %0d errors", name, now_errors - errors_before);
        end
        errors_before = now_errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst        = 1'b1;
        num_cols   = '0;
        pixel_data = '0;
        pixel_req  = 1'b0;
        win_col    = '0;
        win_req    = 1'b0;
        cols_a     = COL_W'(rand_range(2, MAX_COLS - 1));
        cols_b     = COL_W'(rand_range(2, MAX_COLS - 1));
        // Five rows at cols_a and two at cols_b, five window batches plus one spare
        timeout_cycles = 20 * (5 * int'(cols_a) + 2 * int'(cols_b) + 6 * WINDOWS) + 100;

        apply_reset(cols_a);
        expect_rows_ready(1'b0);
        send_row(3);
        expect_rows_ready(1'b0);
        finish_test("reset");

        send_row(3);
        expect_rows_ready(1'b1);
        check_windows();
        finish_test("priming");

        send_row(3);
        check_windows();
        send_row(3);
        check_windows();
        finish_test("rotation");

        // Longer holds on pixel_req
        send_row(6);
        check_windows();
        if (chk_acked != sent) begin
            tb_errors++;
            $display("Pixel acks seen %0d differ from %0d pixels sent", chk_acked, sent);
        end
        finish_test("backpressure");

        apply_reset(cols_b);
        expect_rows_ready(1'b0);
        send_row(3);
        send_row(3);
        expect_rows_ready(1'b1);
        check_windows();
        finish_test("reconfig");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors_before);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tests/row_buffer_checker.sv */
`timescale 1ns/1ps

module row_buffer_checker #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512,
    localparam int COL_W      = $clog2(MAX_COLS),
    localparam int WIN_W      = rowbuf_pkg::WIN_PIXELS * PIXEL_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [COL_W-1:0]       num_cols,
    input  logic [PIXEL_WIDTH-1:0] pixel_data,
    input  logic                   pixel_ack,
    input  logic [COL_W-1:0]       win_col,
    input  logic                   win_req,
    input  logic                   win_ack,
    input  logic [WIN_W-1:0]       win_data,
    input  logic                   rows_ready,
    output int                     errors,
    output int                     acked
);

    // Model of the two buffered rows
    logic [PIXEL_WIDTH-1:0] rows [rowbuf_pkg::ROW_HALVES][MAX_COLS];
    logic                   newest;
    logic                   target;
    logic [COL_W-1:0]       col;
    logic [COL_W-1:0]       next_col;
    logic [WIN_W-1:0]       expected;
    logic [WIN_W-1:0]       win_data_d;
    logic                   rst_d;
    logic                   pixel_ack_d;
    logic                   win_ack_d;
    logic                   win_req_d;
    int                     rows_done;
    int                     err_cnt = 0;
    int                     ack_cnt = 0;
    rowbuf_pkg::wr_phase_e  phase;

    assign errors = err_cnt;
    assign acked  = ack_cnt;

    always_comb begin
        if (rows_done == 0) begin
            phase = rowbuf_pkg::phase_prime_first;
        end else if (rows_done == 1) begin
            phase = rowbuf_pkg::phase_prime_second;
        end else begin
            phase = rowbuf_pkg::phase_rotate;
        end
    end

    task automatic note_mismatch(input string sig, input logic [WIN_W-1:0] exp,
                                 input logic [WIN_W-1:0] got);
        err_cnt++;
        $display("ERR t=%0t %s exp=%h got=%h phase=%s", $time, sig, exp, got, phase.name());
    endtask

    task automatic note_failure(input string what);
        err_cnt++;
        $display("Failure at t=%0t in phase %s: %s", $time, phase.name(), what);
    endtask

    ////////////////////////////////////////////////////////////
    // Model update and comparison
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            if (rst_d && (pixel_ack || win_ack || rows_ready)) begin
                note_failure("an ack or rows_ready is high during reset");
            end
            col       = '0;
            newest    = 1'b0;
            rows_done = 0;
        end else begin
            // One pixel taken per rising pixel_ack
            if (pixel_ack && !pixel_ack_d) begin
                ack_cnt++;
                target = (rows_done < 2) ? rows_done[0] : ~newest;
                rows[target][col] = pixel_data;
                if (col == num_cols - COL_W'(1)) begin
                    col    = '0;
                    newest = target;
                    rows_done++;
                end else begin
                    col = col + COL_W'(1);
                end
            end
            if (rows_ready !== (rows_done >= 2)) begin
                note_mismatch("rows_ready", WIN_W'(rows_done >= 2), WIN_W'(rows_ready));
            end
            if (win_ack && !win_ack_d) begin
                next_col = win_col + COL_W'(1);
                expected = {rows[newest][next_col], rows[newest][win_col],
                            rows[~newest][next_col], rows[~newest][win_col]};
                if (win_data !== expected) begin
                    note_mismatch("win_data", expected, win_data);
                end
            end
            if (win_ack && win_ack_d && win_data !== win_data_d) begin
                note_mismatch("win_data (held)", win_data_d, win_data);
            end
            if (!win_ack && win_ack_d && win_req_d) begin
                note_failure("win_ack fell while win_req was still high");
            end
        end
        rst_d       <= rst;
        pixel_ack_d <= pixel_ack;
        win_ack_d   <= win_ack;
        win_req_d   <= win_req;
        win_data_d  <= win_data;
    end

endmodule

/* tests/row_buffer_sva.sv */
`timescale 1ns/1ps

module row_buffer_sva (
    input logic               clk,
    input logic               rst,
    input rowbuf_pkg::grant_e grant,
    input logic               wr_req,
    input logic               wr_ack,
    input logic               rd_req,
    input logic               rd_ack
);

    // Assertion failures so far
    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////
    // Four-phase rules on both memory channels
    ////////////////////////////////////////////////////////////

    // Ack only answers a pending request
    assert property (@(posedge clk) disable iff (rst) $rose(wr_ack) |-> wr_req)
        else begin
            fail_cnt++;
            $error("writer ack rose without a request");
        end
    assert property (@(posedge clk) disable iff (rst) $rose(rd_ack) |-> rd_req)
        else begin
            fail_cnt++;
            $error("reader ack rose without a request");
        end

    // One owner of the RAM at a time
    assert property (@(posedge clk) disable iff (rst) !(wr_ack && rd_ack))
        else begin
            fail_cnt++;
            $error("writer and reader acks high together");
        end
    assert property (@(posedge clk) disable iff (rst)
        wr_ack |-> grant == rowbuf_pkg::grant_writer)
        else begin
            fail_cnt++;
            $error("writer ack without writer grant");
        end

    // Release follows the requester
    assert property (@(posedge clk) disable iff (rst) $fell(wr_ack) |-> $past(!wr_req))
        else begin
            fail_cnt++;
            $error("writer ack fell before its request fell");
        end
    assert property (@(posedge clk) disable iff (rst) $fell(rd_ack) |-> $past(!rd_req))
        else begin
            fail_cnt++;
            $error("reader ack fell before its request fell");
        end

endmodule

bind rowbuf_arbiter row_buffer_sva arbiter_sva (
    .clk    (clk),
    .rst    (rst),
    .grant  (grant),
    .wr_req (wr_port.req),
    .wr_ack (wr_port.ack),
    .rd_req (rd_port.req),
    .rd_ack (rd_port.ack)
);

/* logic/row_buffer_top.sv */
`timescale 1ns/1ps

module row_buffer_top #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512,
    localparam int COL_W      = $clog2(MAX_COLS),
    localparam int WIN_W      = rowbuf_pkg::WIN_PIXELS * PIXEL_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [COL_W-1:0]       num_cols,
    input  logic [PIXEL_WIDTH-1:0] pixel_data,
    input  logic                   pixel_req,
    output logic                   pixel_ack,
    input  logic [COL_W-1:0]       win_col,
    input  logic                   win_req,
    output logic                   win_ack,
    output logic [WIN_W-1:0]       win_data,
    output logic                   rows_ready
);

    localparam int ADDR_W = $clog2(rowbuf_pkg::ROW_HALVES) + COL_W;

    logic                   newest_half;
    logic                   ram_en;
    logic                   ram_we;
    logic [ADDR_W-1:0]      ram_addr;
    logic [PIXEL_WIDTH-1:0] ram_wdata;
    logic [PIXEL_WIDTH-1:0] ram_rdata;

    ////////////////////////////////////////////////////////////
    // Memory request channels
    ////////////////////////////////////////////////////////////

    rowbuf_mem_if #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) wr_mem ();
    rowbuf_mem_if #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) rd_mem ();

    row_writer #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) u_writer (
        .clk         (clk),
        .rst         (rst),
        .num_cols    (num_cols),
        .pixel_data  (pixel_data),
        .pixel_req   (pixel_req),
        .pixel_ack   (pixel_ack),
        .rows_ready  (rows_ready),
        .newest_half (newest_half),
        .mem         (wr_mem.peer)
    );

    window_reader #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) u_reader (
        .clk         (clk),
        .rst         (rst),
        .win_col     (win_col),
        .win_req     (win_req),
        .rows_ready  (rows_ready),
        .newest_half (newest_half),
        .win_ack     (win_ack),
        .win_data    (win_data),
        .mem         (rd_mem.peer)
    );

    rowbuf_arbiter #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .wr_port   (wr_mem.arbiter),
        .rd_port   (rd_mem.arbiter),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    rowbuf_ram #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* logic/rowbuf_arbiter.sv */
`timescale 1ns/1ps

module rowbuf_arbiter #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512,
    localparam int ADDR_W     = $clog2(rowbuf_pkg::ROW_HALVES) + $clog2(MAX_COLS)
) (
    input  logic                   clk,
    input  logic                   rst,
    rowbuf_mem_if.arbiter          wr_port,
    rowbuf_mem_if.arbiter          rd_port,
    output logic                   ram_en,
    output logic                   ram_we,
    output logic [ADDR_W-1:0]      ram_addr,
    output logic [PIXEL_WIDTH-1:0] ram_wdata,
    input  logic [PIXEL_WIDTH-1:0] ram_rdata
);

    rowbuf_pkg::grant_e grant;
    logic [1:0]         cnt;
    logic               req_sel;
    logic               we_sel;
    logic               ack_sel;
    logic               access_done;

    ////////////////////////////////////////////////////////////
    // Granted peer onto the RAM
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (grant)
            rowbuf_pkg::grant_writer: begin
                req_sel   = wr_port.req;
                we_sel    = wr_port.we;
                ack_sel   = wr_port.ack;
                ram_addr  = wr_port.addr;
                ram_wdata = wr_port.wdata;
            end
            rowbuf_pkg::grant_reader: begin
                req_sel   = rd_port.req;
                we_sel    = rd_port.we;
                ack_sel   = rd_port.ack;
                ram_addr  = rd_port.addr;
                ram_wdata = rd_port.wdata;
            end
            default: begin
                req_sel   = 1'b0;
                we_sel    = 1'b0;
                ack_sel   = 1'b0;
                ram_addr  = wr_port.addr;
                ram_wdata = wr_port.wdata;
            end
        endcase
    end

    // One RAM access, in the first granted cycle
    assign ram_en      = (grant != rowbuf_pkg::grant_none) && (cnt == 2'd0);
    assign ram_we      = ram_en && we_sel;
    // Reads wait one more cycle for the registered RAM output
    assign access_done = we_sel ? (cnt == 2'd0) : (cnt == 2'd1);

    assign wr_port.rdata = (grant == rowbuf_pkg::grant_writer) ? ram_rdata : '0;
    assign rd_port.rdata = (grant == rowbuf_pkg::grant_reader) ? ram_rdata : '0;

    ////////////////////////////////////////////////////////////
    // Grant and ack sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= rowbuf_pkg::grant_none;
            cnt         <= '0;
            wr_port.ack <= 1'b0;
            rd_port.ack <= 1'b0;
        end else if (grant == rowbuf_pkg::grant_none) begin
            cnt <= '0;
            // Fixed priority, writer first
            if (wr_port.req) begin
                grant <= rowbuf_pkg::grant_writer;
            end else if (rd_port.req) begin
                grant <= rowbuf_pkg::grant_reader;
            end
        end else if (!ack_sel) begin
            cnt <= cnt + 2'd1;
            if (access_done) begin
                if (grant == rowbuf_pkg::grant_writer) begin
                    wr_port.ack <= 1'b1;
                end else begin
                    rd_port.ack <= 1'b1;
                end
            end
        end else if (!req_sel) begin
            wr_port.ack <= 1'b0;
            rd_port.ack <= 1'b0;
            grant       <= rowbuf_pkg::grant_none;
        end
    end

endmodule

/* logic/window_reader.sv */
`timescale 1ns/1ps

module window_reader #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512,
    localparam int COL_W      = $clog2(MAX_COLS),
    localparam int WIN_W      = rowbuf_pkg::WIN_PIXELS * PIXEL_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [COL_W-1:0] win_col,
    input  logic             win_req,
    input  logic             rows_ready,
    input  logic             newest_half,
    output logic             win_ack,
    output logic [WIN_W-1:0] win_data,
    rowbuf_mem_if.peer       mem
);

    localparam int HALF_W = $clog2(rowbuf_pkg::ROW_HALVES);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_read  = 2'd1;
    localparam logic [1:0] st_drain = 2'd2;
    localparam logic [1:0] st_hold  = 2'd3;

    logic [1:0]        state;
    logic [1:0]        idx;
    logic [HALF_W-1:0] half;
    logic [COL_W-1:0]  col;

    ////////////////////////////////////////////////////////////
    // Read address in packing order
    ////////////////////////////////////////////////////////////

    // Reads 0 and 1 hit the older row, 2 and 3 the newer
    assign half      = idx[1] ? HALF_W'(newest_half) : HALF_W'(~newest_half);
    assign col       = win_col + COL_W'(idx[0]);
    assign mem.addr  = {half, col};
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;

    ////////////////////////////////////////////////////////////
    // Read sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            idx     <= '0;
            mem.req <= 1'b0;
            win_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (win_req && rows_ready) begin
                        idx     <= '0;
                        mem.req <= 1'b1;
                        state   <= st_read;
                    end
                end
                st_read: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        state   <= st_drain;
                    end
                end
                st_drain: begin
                    // Next read only once the arbiter has dropped ack
                    if (!mem.ack) begin
                        if (idx == 2'd3) begin
                            win_ack <= 1'b1;
                            state   <= st_hold;
                        end else begin
                            idx     <= idx + 2'd1;
                            mem.req <= 1'b1;
                            state   <= st_read;
                        end
                    end
                end
                default: begin
                    if (!win_req) begin
                        win_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
            endcase
        end
    end

    // First read ends up in the lowest slice after four shifts
    always_ff @(posedge clk) begin
        if (state == st_read && mem.ack) begin
            win_data <= {mem.rdata, win_data[WIN_W-1:PIXEL_WIDTH]};
        end
    end

endmodule

/* logic/row_writer.sv */
`timescale 1ns/1ps

module row_writer #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512,
    localparam int COL_W      = $clog2(MAX_COLS)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [COL_W-1:0]       num_cols,
    input  logic [PIXEL_WIDTH-1:0] pixel_data,
    input  logic                   pixel_req,
    output logic                   pixel_ack,
    output logic                   rows_ready,
    output logic                   newest_half,
    rowbuf_mem_if.peer             mem
);

    localparam int HALF_W = $clog2(rowbuf_pkg::ROW_HALVES);

    rowbuf_pkg::wr_phase_e phase;
    logic [COL_W-1:0]      col;
    logic [HALF_W-1:0]     half;
    logic                  last_col;
    logic                  start;

    assign last_col = (col == num_cols - COL_W'(1));
    // New pixel offered while both handshakes are at rest
    assign start    = pixel_req && !mem.req && !pixel_ack;
    assign mem.we   = 1'b1;

    // Target half of the incoming row
    always_comb begin
        case (phase)
            rowbuf_pkg::phase_prime_first:  half = HALF_W'(0);
            rowbuf_pkg::phase_prime_second: half = HALF_W'(1);
            default:                        half = HALF_W'(~newest_half);
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pixel and memory handshakes, row tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= rowbuf_pkg::phase_prime_first;
            col         <= '0;
            newest_half <= 1'b0;
            rows_ready  <= 1'b0;
            pixel_ack   <= 1'b0;
            mem.req     <= 1'b0;
        end else begin
            if (start) begin
                mem.req <= 1'b1;
            end
            // Write done, so the pixel is taken
            if (mem.req && mem.ack) begin
                mem.req   <= 1'b0;
                pixel_ack <= 1'b1;
                if (last_col) begin
                    col <= '0;
                    case (phase)
                        rowbuf_pkg::phase_prime_first: begin
                            phase <= rowbuf_pkg::phase_prime_second;
                        end
                        rowbuf_pkg::phase_prime_second: begin
                            phase       <= rowbuf_pkg::phase_rotate;
                            newest_half <= 1'b1;
                            rows_ready  <= 1'b1;
                        end
                        default: begin
                            // Completed row replaced the older one
                            newest_half <= ~newest_half;
                        end
                    endcase
                end else begin
                    col <= col + COL_W'(1);
                end
            end
            // Wait for the arbiter to release too
            if (pixel_ack && !pixel_req && !mem.ack) begin
                pixel_ack <= 1'b0;
            end
        end
    end

    // Address and pixel captured as the request rises
    always_ff @(posedge clk) begin
        if (start) begin
            mem.addr  <= {half, col};
            mem.wdata <= pixel_data;
        end
    end

endmodule

/* logic/rowbuf_ram.sv */
`timescale 1ns/1ps

module rowbuf_ram #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512,
    localparam int DEPTH      = rowbuf_pkg::ROW_HALVES * MAX_COLS,
    localparam int ADDR_W     = $clog2(DEPTH)
) (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [ADDR_W-1:0]      addr,
    input  logic [PIXEL_WIDTH-1:0] wdata,
    output logic [PIXEL_WIDTH-1:0] rdata
);

    // Both rows, half-select in the top address bit
    logic [PIXEL_WIDTH-1:0] mem [DEPTH];

    // Read-first, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

/* logic/rowbuf_mem_if.sv */
`timescale 1ns/1ps

interface rowbuf_mem_if #(
    parameter int PIXEL_WIDTH = 18,
    parameter int MAX_COLS    = 512
);
    // Half-select bit above the column
    localparam int ADDR_WIDTH = $clog2(rowbuf_pkg::ROW_HALVES) + $clog2(MAX_COLS);

    logic                   req;
    logic                   we;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [PIXEL_WIDTH-1:0] wdata;
    logic                   ack;
    // Read data, valid while ack is high
    logic [PIXEL_WIDTH-1:0] rdata;

    modport peer (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

/* logic/rowbuf_pkg.sv */
package rowbuf_pkg;

    ////////////////////////////////////////////////////////////
    // Window and row geometry
    ////////////////////////////////////////////////////////////

    // Pixels in one 2x2 window
    localparam int WIN_PIXELS = 4;

    // Rows kept in the row memory, one per half
    localparam int ROW_HALVES = 2;

    ////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////

    // Owner of the shared row memory
    typedef enum logic [1:0] {
        grant_none   = 2'd0,
        grant_writer = 2'd1,
        grant_reader = 2'd2
    } grant_e;

    // Where incoming rows land
    typedef enum logic [1:0] {
        phase_prime_first  = 2'd0,
        phase_prime_second = 2'd1,
        phase_rotate       = 2'd2
    } wr_phase_e;

endpackage
